/* alu/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
  input  ex_pipe_pkg::alu_req_t        alu_req_i,
  output logic [ex_pipe_pkg::XLEN-1:0] result_o,
  output logic                         cmp_result_o
);

  // Operands
  logic [ex_pipe_pkg::XLEN-1:0] op_a;
  logic [ex_pipe_pkg::XLEN-1:0] op_b;

  // Shared adder for ADD and SUB
  logic                         is_sub;
  logic [ex_pipe_pkg::XLEN-1:0] adder_b;
  logic [ex_pipe_pkg::XLEN-1:0] adder_result;

  // Shifter
  logic [4:0]                   shamt;
  logic [ex_pipe_pkg::XLEN-1:0] sll_result;
  logic [ex_pipe_pkg::XLEN-1:0] srl_result;
  logic [ex_pipe_pkg::XLEN-1:0] sra_result;

  // Comparator
  logic                         is_equal;
  logic                         is_less_s;
  logic                         is_less_u;
  logic                         cmp;

  assign op_a = alu_req_i.op_a;
  assign op_b = alu_req_i.op_b;

  //////////////////////////////
  // Adder
  //////////////////////////////

  // Two's complement subtract, invert b and carry in one
  assign is_sub       = (alu_req_i.op == ex_op_pkg::ALU_SUB);
  assign adder_b      = is_sub ? ~op_b : op_b;
  assign adder_result = op_a + adder_b + {{(ex_pipe_pkg::XLEN-1){1'b0}}, is_sub};

  //////////////////////////////
  // Shifter
  //////////////////////////////

  // Only the low five bits of b count
  assign shamt      = op_b[4:0];
  assign sll_result = op_a << shamt;
  assign srl_result = op_a >> shamt;
  // Sign bit fills from the left
  assign sra_result = $signed(op_a) >>> shamt;

  //////////////////////////////
  // Comparator
  //////////////////////////////

  assign is_equal  = (op_a == op_b);
  assign is_less_s = ($signed(op_a) < $signed(op_b));
  assign is_less_u = (op_a < op_b);

  // Compare bit per operation, zero for arithmetic
  always_comb begin
    case (alu_req_i.op)
      ex_op_pkg::ALU_EQ:   cmp = is_equal;
      ex_op_pkg::ALU_NE:   cmp = ~is_equal;
      ex_op_pkg::ALU_LT:   cmp = is_less_s;
      ex_op_pkg::ALU_GE:   cmp = ~is_less_s;
      ex_op_pkg::ALU_LTU:  cmp = is_less_u;
      ex_op_pkg::ALU_GEU:  cmp = ~is_less_u;
      ex_op_pkg::ALU_SLT:  cmp = is_less_s;
      ex_op_pkg::ALU_SLTU: cmp = is_less_u;
      default:             cmp = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp;

  //////////////////////////////
  // Result mux
  //////////////////////////////

  always_comb begin
    case (alu_req_i.op)
      ex_op_pkg::ALU_ADD,
      ex_op_pkg::ALU_SUB: result_o = adder_result;
      ex_op_pkg::ALU_AND: result_o = op_a & op_b;
      ex_op_pkg::ALU_OR:  result_o = op_a | op_b;
      ex_op_pkg::ALU_XOR: result_o = op_a ^ op_b;
      ex_op_pkg::ALU_SLL: result_o = sll_result;
      ex_op_pkg::ALU_SRL: result_o = srl_result;
      ex_op_pkg::ALU_SRA: result_o = sra_result;
      // Compares and set-less-than, zero-extended bit
      default:            result_o = {{(ex_pipe_pkg::XLEN-1){1'b0}}, cmp};
    endcase
  end

endmodule

/* common/ex_op_pkg.sv */
package ex_op_pkg;

  //////////////////////////////
  // Operator widths
  //////////////////////////////

  // ALU operator code, compare group in the upper half
  localparam int unsigned ALU_OP_W  = 5;
  // Multiplier operator code, bit 2 marks the high-half group
  localparam int unsigned MULT_OP_W = 3;

  //////////////////////////////
  // ALU operations
  //////////////////////////////

  typedef enum logic [ALU_OP_W-1:0] {
    // Adder based
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    // Bitwise logic
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    // Shifts, amount from b[4:0]
    ALU_SLL  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    // Set-less-than, result is the compare bit
    ALU_SLT  = 5'h08,
    ALU_SLTU = 5'h09,
    // Branch compares
    ALU_EQ   = 5'h10,
    ALU_NE   = 5'h11,
    ALU_LT   = 5'h12,
    ALU_GE   = 5'h13,
    ALU_LTU  = 5'h14,
    ALU_GEU  = 5'h15
  } alu_op_e;

  //////////////////////////////
  // Multiplier operations
  //////////////////////////////

  typedef enum logic [MULT_OP_W-1:0] {
    // Single cycle, low half
    MULT_MUL    = 3'h0,
    MULT_MAC    = 3'h1,
    // Two cycles, upper half of the 64-bit product
    MULT_MULH   = 3'h4,
    MULT_MULHSU = 3'h5,
    MULT_MULHU  = 3'h6
  } mult_op_e;

endpackage

/* common/ex_pipe_pkg.sv */
package ex_pipe_pkg;

  //////////////////////////////
  // Datapath widths
  //////////////////////////////

  // Integer register width
  localparam int unsigned XLEN       = 32;
  // Register file address, upper bit selects the FP half
  localparam int unsigned REG_ADDR_W = 6;

  //////////////////////////////
  // Requests from ID
  //////////////////////////////

  // ALU request, operand c carries the jump target
  typedef struct packed {
    ex_op_pkg::alu_op_e op;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [XLEN-1:0]    op_c;
    logic               en;
  } alu_req_t;

  // Multiplier request, operand c is the MAC addend
  typedef struct packed {
    ex_op_pkg::mult_op_e op;
    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [XLEN-1:0]     op_c;
    logic                en;
  } mult_req_t;

  //////////////////////////////
  // Register file write port
  //////////////////////////////

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wr_port_t;

endpackage

/* dv/ex_stage_checker.sv */
`timescale 1ns/1ps

module ex_stage_checker (
  input  logic                         clk,
  input  logic                         rst_n,

  // Observed DUT ports
  input  ex_pipe_pkg::wr_port_t        fw_port_i,
  input  ex_pipe_pkg::wr_port_t        wb_port_i,
  input  logic [ex_pipe_pkg::XLEN-1:0] jump_target_i,
  input  logic                         branch_decision_i,
  input  logic                         mult_multicycle_i,
  input  logic                         ex_ready_i,
  input  logic                         ex_valid_i,

  // Expected values from the testbench
  input  logic                         chk_en_i,
  input  logic                         stall_mode_i,
  input  ex_pipe_pkg::wr_port_t        exp_fw_i,
  input  logic                         exp_branch_i,
  input  logic [ex_pipe_pkg::XLEN-1:0] exp_jump_i,
  input  logic                         exp_multicycle_i,
  input  int                           exp_stalls_i,
  input  logic                         exp_ready_stall_i,
  input  logic                         wb_chk_en_i,
  input  ex_pipe_pkg::wr_port_t        exp_wb_i,

  output int                           error_count_o,
  output int                           check_count_o
);

  // Cycles with ex_ready_o low for the current instruction
  int                    stall_cnt;
  // WB port seen on the first stalled edge
  ex_pipe_pkg::wr_port_t hold_ref;
  logic                  in_stall;

  initial begin
    error_count_o = 0;
    check_count_o = 0;
    stall_cnt     = 0;
    in_stall      = 1'b0;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count_o++;
    if (got !== exp) begin
      error_count_o++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Execute side
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n && chk_en_i && stall_mode_i) begin
      // Stalled so nothing may leave EX
      compare("ex_valid_o", 32'(ex_valid_i), 32'(1'b0));
      compare("ex_ready_o", 32'(ex_ready_i), 32'(exp_ready_stall_i));
      if (!in_stall) begin
        hold_ref = wb_port_i;
        in_stall = 1'b1;
      end else begin
        compare("wb_port_o.we", 32'(wb_port_i.we), 32'(hold_ref.we));
        compare("wb_port_o.waddr", 32'(wb_port_i.waddr), 32'(hold_ref.waddr));
      end
    end else if (rst_n && chk_en_i) begin
      in_stall = 1'b0;
      if (!ex_ready_i) begin
        stall_cnt++;
        // A waiting stage sends nothing on
        compare("ex_valid_o", 32'(ex_valid_i), 32'(1'b0));
      end else begin
        // Instruction leaves EX on this edge
        compare("ex_valid_o", 32'(ex_valid_i), 32'(1'b1));
        compare("fw_port_o.we", 32'(fw_port_i.we), 32'(exp_fw_i.we));
        compare("fw_port_o.waddr", 32'(fw_port_i.waddr), 32'(exp_fw_i.waddr));
        compare("fw_port_o.wdata", fw_port_i.wdata, exp_fw_i.wdata);
        compare("branch_decision_o", 32'(branch_decision_i), 32'(exp_branch_i));
        compare("jump_target_o", jump_target_i, exp_jump_i);
        compare("mult_multicycle_o", 32'(mult_multicycle_i), 32'(exp_multicycle_i));
        // ex_ready_o low cycles before completion
        compare("ex_ready_o stall cycles", stall_cnt, exp_stalls_i);
        stall_cnt = 0;
      end
    end else begin
      in_stall  = 1'b0;
      stall_cnt = 0;
    end
  end

  //////////////////////////////
  // Writeback side
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n && wb_chk_en_i) begin
      compare("wb_port_o.we", 32'(wb_port_i.we), 32'(exp_wb_i.we));
      // Address and data only mean something with a write
      if (exp_wb_i.we) begin
        compare("wb_port_o.waddr", 32'(wb_port_i.waddr), 32'(exp_wb_i.waddr));
        compare("wb_port_o.wdata", wb_port_i.wdata, exp_wb_i.wdata);
      end
    end
  end

endmodule

/* dv/ex_stage_stimulus.txt */
# kind aop mop a b c csr csr_rdata alu_we alu_waddr we waddr lsu_rdata err branch wb_rdy lsu_rdy
#   exp_fw_data exp_branch exp_multicycle; kind 0 alu 1 mult 2 csr 3 load 4 stall 5 random alu
0 00 0 00000005 00000003 00001000 0 00000000 1 05 0 00 00000000 0 0 1 1 00000008 0 0
0 01 0 00000005 00000007 00001004 0 00000000 1 06 0 00 00000000 0 0 1 1 fffffffe 0 0
0 02 0 f0f0f0f0 ff00ff00 00000000 0 00000000 1 07 0 00 00000000 0 0 1 1 f000f000 0 0
0 03 0 f0f0f0f0 0f0f0000 00000000 0 00000000 1 08 0 00 00000000 0 0 1 1 fffff0f0 0 0
0 04 0 aaaaaaaa ffff0000 00000000 0 00000000 1 09 0 00 00000000 0 0 1 1 5555aaaa 0 0
0 05 0 00000001 00000024 00000000 0 00000000 1 0a 0 00 00000000 0 0 1 1 00000010 0 0
0 06 0 80000000 0000001f 00000000 0 00000000 1 0b 0 00 00000000 0 0 1 1 00000001 0 0
0 07 0 80000000 00000004 00000000 0 00000000 1 0c 0 00 00000000 0 0 1 1 f8000000 0 0
0 08 0 ffffffff 00000001 00000000 0 00000000 1 0d 0 00 00000000 0 0 1 1 00000001 1 0
0 09 0 ffffffff 00000001 00000000 0 00000000 1 0e 0 00 00000000 0 0 1 1 00000000 0 0
0 10 0 00001234 00001234 00002000 0 00000000 0 00 0 00 00000000 0 1 1 1 00000001 1 0
0 11 0 00001234 00001234 00002010 0 00000000 0 00 0 00 00000000 0 1 1 1 00000000 0 0
0 12 0 fffffff0 00000010 00002020 0 00000000 0 00 0 00 00000000 0 1 1 1 00000001 1 0
0 13 0 fffffff0 00000010 00002030 0 00000000 0 00 0 00 00000000 0 1 1 1 00000000 0 0
0 14 0 fffffff0 00000010 00002040 0 00000000 0 00 0 00 00000000 0 1 1 1 00000000 0 0
0 15 0 fffffff0 00000010 00002050 0 00000000 0 00 0 00 00000000 0 1 1 1 00000001 1 0
1 00 0 00000007 00000006 00000000 0 00000000 1 10 0 00 00000000 0 0 1 1 0000002a 0 0
1 00 1 00000003 00000004 00000064 0 00000000 1 11 0 00 00000000 0 0 1 1 00000070 0 0
1 00 4 ffffffff ffffffff 00000000 0 00000000 1 12 0 00 00000000 0 0 1 1 00000000 0 1
1 00 4 80000000 00000002 00000000 0 00000000 1 13 0 00 00000000 0 0 1 1 ffffffff 0 1
1 00 5 ffffffff ffffffff 00000000 0 00000000 1 14 0 00 00000000 0 0 1 1 ffffffff 0 1
1 00 6 ffffffff ffffffff 00000000 0 00000000 1 15 0 00 00000000 0 0 1 1 fffffffe 0 1
1 00 6 00010000 00010000 00000000 0 00000000 1 16 0 00 00000000 0 0 1 1 00000001 0 1
2 00 0 00000001 00000002 00000000 1 cafe0001 1 17 0 00 00000000 0 0 1 1 cafe0001 0 0
3 00 0 00000000 00000000 00000000 0 00000000 0 00 1 0a deadbeef 0 0 1 1 00000000 0 0
3 00 0 00000000 00000000 00000000 0 00000000 0 00 1 0b 12345678 1 0 1 1 00000000 0 0
4 00 0 00000002 00000003 00000000 0 00000000 1 18 0 00 00000000 0 0 0 1 00000005 0 0
4 00 0 00000004 00000003 00000000 0 00000000 1 19 0 00 00000000 0 0 1 0 00000007 0 0
4 10 0 00000004 00000004 00003000 0 00000000 0 00 0 00 00000000 0 1 0 1 00000001 1 0
5 00 0 00000000 00000000 00000000 0 00000000 1 1a 0 00 00000000 0 0 1 1 00000000 0 0
5 01 0 00000000 00000000 00000000 0 00000000 1 1b 0 00 00000000 0 0 1 1 00000000 0 0
5 07 0 00000000 00000000 00000000 0 00000000 1 1c 0 00 00000000 0 0 1 1 00000000 0 0
5 08 0 00000000 00000000 00000000 0 00000000 1 1d 0 00 00000000 0 0 1 1 00000000 0 0
5 12 0 00000000 00000000 00004000 0 00000000 0 00 0 00 00000000 0 1 1 1 00000000 0 0

/* dv/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb;

  localparam int TIMEOUT_CYCLES = 20;

  logic                               clk;
  logic                               rst_n;
  ex_pipe_pkg::alu_req_t              alu_req;
  ex_pipe_pkg::mult_req_t             mult_req;
  logic                               regfile_alu_we;
  logic [ex_pipe_pkg::REG_ADDR_W-1:0] regfile_alu_waddr;
  logic                               regfile_we;
  logic [ex_pipe_pkg::REG_ADDR_W-1:0] regfile_waddr;
  logic                               csr_access;
  logic [ex_pipe_pkg::XLEN-1:0]       csr_rdata;
  logic                               lsu_en;
  logic [ex_pipe_pkg::XLEN-1:0]       lsu_rdata;
  logic                               lsu_ready_ex;
  logic                               lsu_err;
  logic                               branch_in_ex;
  logic                               wb_ready;
  ex_pipe_pkg::wr_port_t              fw_port;
  ex_pipe_pkg::wr_port_t              wb_port;
  logic [ex_pipe_pkg::XLEN-1:0]       jump_target;
  logic                               branch_decision;
  logic                               mult_multicycle;
  logic                               ex_ready;
  logic                               ex_valid;

  // Expected values for the checker
  logic                               chk_en;
  logic                               stall_mode;
  ex_pipe_pkg::wr_port_t              exp_fw;
  logic                               exp_branch;
  logic [ex_pipe_pkg::XLEN-1:0]       exp_jump;
  logic                               exp_multicycle;
  int                                 exp_stalls;
  logic                               exp_ready_stall;
  logic                               wb_chk_en;
  ex_pipe_pkg::wr_port_t              exp_wb;
  int                                 error_count;
  int                                 check_count;

  // Stimulus fields, one line
  logic [31:0] f_kind, f_aop, f_mop, f_a, f_b, f_c, f_csr, f_crd, f_awe, f_awa;
  logic [31:0] f_we, f_wa, f_lrd, f_err, f_br, f_wbr, f_lsr, f_exp, f_exp_br, f_exp_mc;

  int    seed;
  int    fd;
  int    nfields;
  int    file_errors;
  logic  timed_out;
  string line;

  ex_stage ex_stage_i (
    .clk                 ( clk               ),
    .rst_n               ( rst_n             ),
    .alu_req_i           ( alu_req           ),
    .mult_req_i          ( mult_req          ),
    .regfile_alu_we_i    ( regfile_alu_we    ),
    .regfile_alu_waddr_i ( regfile_alu_waddr ),
    .regfile_we_i        ( regfile_we        ),
    .regfile_waddr_i     ( regfile_waddr     ),
    .csr_access_i        ( csr_access        ),
    .csr_rdata_i         ( csr_rdata         ),
    .lsu_en_i            ( lsu_en            ),
    .lsu_rdata_i         ( lsu_rdata         ),
    .lsu_ready_ex_i      ( lsu_ready_ex      ),
    .lsu_err_i           ( lsu_err           ),
    .branch_in_ex_i      ( branch_in_ex      ),
    .wb_ready_i          ( wb_ready          ),
    .fw_port_o           ( fw_port           ),
    .wb_port_o           ( wb_port           ),
    .jump_target_o       ( jump_target       ),
    .branch_decision_o   ( branch_decision   ),
    .mult_multicycle_o   ( mult_multicycle   ),
    .ex_ready_o          ( ex_ready          ),
    .ex_valid_o          ( ex_valid          )
  );

  ex_stage_checker checker_i (
    .clk               ( clk             ),
    .rst_n             ( rst_n           ),
    .fw_port_i         ( fw_port         ),
    .wb_port_i         ( wb_port         ),
    .jump_target_i     ( jump_target     ),
    .branch_decision_i ( branch_decision ),
    .mult_multicycle_i ( mult_multicycle ),
    .ex_ready_i        ( ex_ready        ),
    .ex_valid_i        ( ex_valid        ),
    .chk_en_i          ( chk_en          ),
    .stall_mode_i      ( stall_mode      ),
    .exp_fw_i          ( exp_fw          ),
    .exp_branch_i      ( exp_branch      ),
    .exp_jump_i        ( exp_jump        ),
    .exp_multicycle_i  ( exp_multicycle  ),
    .exp_stalls_i      ( exp_stalls      ),
    .exp_ready_stall_i ( exp_ready_stall ),
    .wb_chk_en_i       ( wb_chk_en       ),
    .exp_wb_i          ( exp_wb          ),
    .error_count_o     ( error_count     ),
    .check_count_o     ( check_count     )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Reference model for random ALU lines
  //////////////////////////////

  // Compare rule, SLT and SLTU included
  function automatic logic alu_cmp(input ex_op_pkg::alu_op_e op, input logic [31:0] a,
                                   input logic [31:0] b);
    case (op)
      ex_op_pkg::ALU_EQ:   return a == b;
      ex_op_pkg::ALU_NE:   return a != b;
      ex_op_pkg::ALU_LT,
      ex_op_pkg::ALU_SLT:  return $signed(a) < $signed(b);
      ex_op_pkg::ALU_GE:   return $signed(a) >= $signed(b);
      ex_op_pkg::ALU_LTU,
      ex_op_pkg::ALU_SLTU: return a < b;
      ex_op_pkg::ALU_GEU:  return a >= b;
      default:             return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_data(input ex_op_pkg::alu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
      ex_op_pkg::ALU_ADD: return a + b;
      ex_op_pkg::ALU_SUB: return a - b;
      ex_op_pkg::ALU_AND: return a & b;
      ex_op_pkg::ALU_OR:  return a | b;
      ex_op_pkg::ALU_XOR: return a ^ b;
      ex_op_pkg::ALU_SLL: return a << b[4:0];
      ex_op_pkg::ALU_SRL: return a >> b[4:0];
      ex_op_pkg::ALU_SRA: return $signed(a) >>> b[4:0];
      default:            return {31'b0, alu_cmp(op, a, b)};
    endcase
  endfunction

  // All units off, LSU data kept for WB
  task automatic drive_idle();
    alu_req.en     = 1'b0;
    mult_req.en    = 1'b0;
    csr_access     = 1'b0;
    lsu_en         = 1'b0;
    regfile_alu_we = 1'b0;
    regfile_we     = 1'b0;
    lsu_err        = 1'b0;
    branch_in_ex   = 1'b0;
    wb_ready       = 1'b1;
    lsu_ready_ex   = 1'b1;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!ex_ready && !timed_out) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
        $display("timeout at %0t: ex_ready_o stayed low", $time);
      end else begin
        @(posedge clk);
      end
    end
  endtask

  //////////////////////////////
  // One stimulus line
  //////////////////////////////

  task automatic run_line();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    logic        br;
    a    = f_a;
    b    = f_b;
    data = f_exp;
    br   = f_exp_br[0];
    // Kind 5 takes random operands
    if (f_kind == 5) begin
      a    = $random(seed);
      b    = $random(seed);
      data = alu_data(ex_op_pkg::alu_op_e'(f_aop[4:0]), a, b);
      br   = alu_cmp(ex_op_pkg::alu_op_e'(f_aop[4:0]), a, b);
    end
    @(negedge clk);
    wb_chk_en         = 1'b0;
    alu_req.op        = ex_op_pkg::alu_op_e'(f_aop[4:0]);
    alu_req.op_a      = a;
    alu_req.op_b      = b;
    alu_req.op_c      = f_c;
    alu_req.en        = (f_kind == 0) || (f_kind == 2) || (f_kind == 4) || (f_kind == 5);
    mult_req.op       = ex_op_pkg::mult_op_e'(f_mop[2:0]);
    mult_req.op_a     = a;
    mult_req.op_b     = b;
    mult_req.op_c     = f_c;
    mult_req.en       = (f_kind == 1);
    csr_access        = f_csr[0];
    csr_rdata         = f_crd;
    regfile_alu_we    = f_awe[0];
    regfile_alu_waddr = f_awa[5:0];
    regfile_we        = f_we[0];
    regfile_waddr     = f_wa[5:0];
    lsu_en            = (f_kind == 3);
    lsu_rdata         = f_lrd;
    lsu_err           = f_err[0];
    branch_in_ex      = f_br[0];
    wb_ready          = f_wbr[0];
    lsu_ready_ex      = f_lsr[0];
    // Expected results
    exp_fw.we       = f_awe[0];
    exp_fw.waddr    = f_awa[5:0];
    exp_fw.wdata    = data;
    exp_branch      = br;
    exp_jump        = f_c;
    exp_multicycle  = f_exp_mc[0];
    exp_stalls      = (f_kind == 1 && f_mop[2]) ? 1 : 0;
    exp_ready_stall = f_br[0];
    exp_wb.we       = f_we[0] & ~f_err[0];
    exp_wb.waddr    = f_wa[5:0];
    exp_wb.wdata    = f_lrd;
    chk_en          = 1'b1;
    stall_mode      = (f_kind == 4);
    // Hold the stall a few cycles, then release
    if (f_kind == 4) begin
      repeat (3) @(posedge clk);
      @(negedge clk);
      stall_mode   = 1'b0;
      wb_ready     = 1'b1;
      lsu_ready_ex = 1'b1;
    end
    wait_ready();
    if (!timed_out) begin
      @(negedge clk);
      chk_en    = 1'b0;
      drive_idle();
      wb_chk_en = 1'b1;
      @(posedge clk);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed         = 32'h46970956;
    file_errors  = 0;
    timed_out    = 1'b0;
    rst_n        = 1'b0;
    alu_req      = '0;
    mult_req     = '0;
    csr_rdata    = '0;
    lsu_rdata    = '0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    drive_idle();
    chk_en       = 1'b0;
    stall_mode   = 1'b0;
    wb_chk_en    = 1'b0;
    exp_fw       = '0;
    exp_wb       = '0;
    exp_branch   = 1'b0;
    exp_jump     = '0;
    exp_multicycle  = 1'b0;
    exp_stalls      = 0;
    exp_ready_stall = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("dv/ex_stage_stimulus.txt", "r");
    if (fd == 0) begin
      file_errors++;
      $display("could not open the stimulus file dv/ex_stage_stimulus.txt");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        void'($fgets(line, fd));
        // Skip comments and blank lines
        if (line.len() > 1 && line.getc(0) != 8'h23) begin
          nfields = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f_kind, f_aop, f_mop, f_a, f_b, f_c, f_csr, f_crd, f_awe, f_awa,
            f_we, f_wa, f_lrd, f_err, f_br, f_wbr, f_lsr, f_exp, f_exp_br, f_exp_mc);
          if (nfields != 20) begin
            file_errors++;
            $display("stimulus line has %0d fields instead of 20: %s", nfields, line);
          end else begin
            run_line();
          end
        end
      end
      $fclose(fd);
    end

    @(negedge clk);
    $display("checks %0d, errors %0d, stimulus errors %0d, timeouts %0d",
             check_count, error_count, file_errors, timed_out ? 1 : 0);
    if (!timed_out && error_count == 0 && file_errors == 0 && check_count > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* mult/ex_mult.sv */
`timescale 1ns/1ps

module ex_mult (
  input  logic                         clk,
  input  logic                         rst_n,
  input  ex_pipe_pkg::mult_req_t       mult_req_i,
  input  logic                         ex_ready_i,
  output logic [ex_pipe_pkg::XLEN-1:0] result_o,
  output logic                         ready_o,
  output logic                         multicycle_o
);

  // Second state shows the registered upper half
  typedef enum logic {
    MULT_IDLE,
    MULT_FINISH
  } mult_state_e;

  mult_state_e                       state_q;
  mult_state_e                       state_d;

  // Operand signedness per variant
  logic                              sign_a;
  logic                              sign_b;
  logic                              is_high;
  logic                              load_prod;

  // One extra bit each so one signed multiplier covers all variants
  logic signed [ex_pipe_pkg::XLEN:0]     op_a_ext;
  logic signed [ex_pipe_pkg::XLEN:0]     op_b_ext;
  logic signed [2*ex_pipe_pkg::XLEN+1:0] prod_full;
  logic [2*ex_pipe_pkg::XLEN-1:0]        prod_q;

  assign sign_a  = (mult_req_i.op == ex_op_pkg::MULT_MULH) |
                   (mult_req_i.op == ex_op_pkg::MULT_MULHSU);
  assign sign_b  = (mult_req_i.op == ex_op_pkg::MULT_MULH);
  assign is_high = sign_a | (mult_req_i.op == ex_op_pkg::MULT_MULHU);

  assign op_a_ext  = {sign_a & mult_req_i.op_a[ex_pipe_pkg::XLEN-1], mult_req_i.op_a};
  assign op_b_ext  = {sign_b & mult_req_i.op_b[ex_pipe_pkg::XLEN-1], mult_req_i.op_b};
  // Low half is the same for any signedness
  assign prod_full = op_a_ext * op_b_ext;

  //////////////////////////////
  // High-half FSM
  //////////////////////////////

  always_comb begin
    state_d   = state_q;
    load_prod = 1'b0;
    ready_o   = 1'b1;
    case (state_q)
      MULT_IDLE: begin
        // Capture product, stall one cycle
        if (mult_req_i.en && is_high) begin
          load_prod = 1'b1;
          ready_o   = 1'b0;
          state_d   = MULT_FINISH;
        end
      end
      MULT_FINISH: begin
        // Hold result until the stage moves on
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  assign multicycle_o = (state_q == MULT_FINISH);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Product register
  always_ff @(posedge clk) begin
    if (load_prod) begin
      prod_q <= prod_full[2*ex_pipe_pkg::XLEN-1:0];
    end
  end

  // Result select
  always_comb begin
    case (mult_req_i.op)
      ex_op_pkg::MULT_MUL: result_o = prod_full[ex_pipe_pkg::XLEN-1:0];
      ex_op_pkg::MULT_MAC: result_o = prod_full[ex_pipe_pkg::XLEN-1:0] + mult_req_i.op_c;
      // MULH, MULHSU and MULHU
      default:             result_o = prod_q[2*ex_pipe_pkg::XLEN-1:ex_pipe_pkg::XLEN];
    endcase
  end

endmodule

/* project.f */
common/ex_op_pkg.sv
common/ex_pipe_pkg.sv
alu/ex_alu.sv
mult/ex_mult.sv
rtl/ex_wb_ctrl.sv
rtl/ex_stage.sv
dv/ex_stage_checker.sv
dv/ex_stage_tb.sv

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
  input  logic                               clk,
  input  logic                               rst_n,

  // Unit requests from ID
  input  ex_pipe_pkg::alu_req_t              alu_req_i,
  input  ex_pipe_pkg::mult_req_t             mult_req_i,

  // ALU write port request
  input  logic                               regfile_alu_we_i,
  input  logic [ex_pipe_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,

  // LSU write port request, goes on to WB
  input  logic                               regfile_we_i,
  input  logic [ex_pipe_pkg::REG_ADDR_W-1:0] regfile_waddr_i,

  // CSR read data
  input  logic                               csr_access_i,
  input  logic [ex_pipe_pkg::XLEN-1:0]       csr_rdata_i,

  // LSU
  input  logic                               lsu_en_i,
  input  logic [ex_pipe_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                               lsu_ready_ex_i,
  input  logic                               lsu_err_i,

  // Pipeline control
  input  logic                               branch_in_ex_i,
  input  logic                               wb_ready_i,

  // Write ports
  output ex_pipe_pkg::wr_port_t              fw_port_o,
  output ex_pipe_pkg::wr_port_t              wb_port_o,

  // Towards IF
  output logic [ex_pipe_pkg::XLEN-1:0]       jump_target_o,
  output logic                               branch_decision_o,

  // Status and handshake
  output logic                               mult_multicycle_o,
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  // Unit results
  logic [ex_pipe_pkg::XLEN-1:0] alu_result;
  logic [ex_pipe_pkg::XLEN-1:0] mult_result;
  // Low while a high multiply computes
  logic                         mult_ready;

  // Jump target straight from ID
  assign jump_target_o = alu_req_i.op_c;

  //////////////////////////////
  // ALU
  //////////////////////////////

  // Compare bit doubles as branch decision
  ex_alu alu_i (
    .alu_req_i    ( alu_req_i         ),
    .result_o     ( alu_result        ),
    .cmp_result_o ( branch_decision_o )
  );

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  ex_mult mult_i (
    .clk          ( clk               ),
    .rst_n        ( rst_n             ),
    .mult_req_i   ( mult_req_i        ),
    .ex_ready_i   ( ex_ready_o        ),
    .result_o     ( mult_result       ),
    .ready_o      ( mult_ready        ),
    .multicycle_o ( mult_multicycle_o )
  );

  //////////////////////////////
  // Writeback and handshake
  //////////////////////////////

  ex_wb_ctrl wb_ctrl_i (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .alu_en_i            ( alu_req_i.en        ),
    .mult_en_i           ( mult_req_i.en       ),
    .csr_access_i        ( csr_access_i        ),
    .lsu_en_i            ( lsu_en_i            ),
    .alu_result_i        ( alu_result          ),
    .mult_result_i       ( mult_result         ),
    .csr_rdata_i         ( csr_rdata_i         ),
    .mult_ready_i        ( mult_ready          ),
    .regfile_alu_we_i    ( regfile_alu_we_i    ),
    .regfile_alu_waddr_i ( regfile_alu_waddr_i ),
    .regfile_we_i        ( regfile_we_i        ),
    .regfile_waddr_i     ( regfile_waddr_i     ),
    .lsu_rdata_i         ( lsu_rdata_i         ),
    .lsu_ready_ex_i      ( lsu_ready_ex_i      ),
    .lsu_err_i           ( lsu_err_i           ),
    .branch_in_ex_i      ( branch_in_ex_i      ),
    .wb_ready_i          ( wb_ready_i          ),
    .fw_port_o           ( fw_port_o           ),
    .wb_port_o           ( wb_port_o           ),
    .ex_ready_o          ( ex_ready_o          ),
    .ex_valid_o          ( ex_valid_o          )
  );

endmodule

/* rtl/ex_wb_ctrl.sv */
`timescale 1ns/1ps

module ex_wb_ctrl (
  input  logic                               clk,
  input  logic                               rst_n,

  // Unit enables from ID
  input  logic                               alu_en_i,
  input  logic                               mult_en_i,
  input  logic                               csr_access_i,
  input  logic                               lsu_en_i,

  // Result sources
  input  logic [ex_pipe_pkg::XLEN-1:0]       alu_result_i,
  input  logic [ex_pipe_pkg::XLEN-1:0]       mult_result_i,
  input  logic [ex_pipe_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                               mult_ready_i,

  // Write port requests
  input  logic                               regfile_alu_we_i,
  input  logic [ex_pipe_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                               regfile_we_i,
  input  logic [ex_pipe_pkg::REG_ADDR_W-1:0] regfile_waddr_i,

  // LSU and pipeline control
  input  logic [ex_pipe_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                               lsu_ready_ex_i,
  input  logic                               lsu_err_i,
  input  logic                               branch_in_ex_i,
  input  logic                               wb_ready_i,

  output ex_pipe_pkg::wr_port_t              fw_port_o,
  output ex_pipe_pkg::wr_port_t              wb_port_o,
  output logic                               ex_ready_o,
  output logic                               ex_valid_o
);

  // All units and WB can accept
  logic                               stage_ready;
  // Load write enable after the error check
  logic                               load_we;

  // EX/WB register
  logic                               wb_we_q;
  logic [ex_pipe_pkg::REG_ADDR_W-1:0] wb_waddr_q;

  //////////////////////////////
  // Stage handshake
  //////////////////////////////

  assign stage_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // Branches finish in EX, so never held back
  assign ex_ready_o  = stage_ready | branch_in_ex_i;
  // Independent of ex_ready_o
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & stage_ready;

  //////////////////////////////
  // ALU write port
  //////////////////////////////

  always_comb begin
    fw_port_o.we    = regfile_alu_we_i;
    fw_port_o.waddr = regfile_alu_waddr_i;
    fw_port_o.wdata = '0;
    // Later source wins
    if (alu_en_i) begin
      fw_port_o.wdata = alu_result_i;
    end
    if (mult_en_i) begin
      fw_port_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fw_port_o.wdata = csr_rdata_i;
    end
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // Faulting load never writes back
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      wb_we_q <= load_we;
    end else if (wb_ready_i) begin
      // Nothing new, drain the slot
      wb_we_q <= 1'b0;
    end
  end

  // Address only follows a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && load_we) begin
      wb_waddr_q <= regfile_waddr_i;
    end
  end

  // LSU write port, data arrives during WB
  assign wb_port_o.we    = wb_we_q;
  assign wb_port_o.waddr = wb_waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the EX stage testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module ex_stage_tb -f project.f \
  -o ex_stage_sim > build.log 2>&1 &&
./obj_dir/ex_stage_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed"; exit 1; }
grep -q "^TEST RESULT: PASS$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
